// ==== julia_pkg.sv ====
package julia_pkg;

	// Signed fixed point, 1.0 is 1 << FRAC_BITS
	localparam int FRAC_BITS = 13;
	localparam int COORD_W = 32;

	// Panel geometry, shrunk for simulation
	localparam int LCD_W = 8;
	localparam int LCD_H = 4;

	localparam int ITER_W = 5;
	localparam int ENGINE_COUNT = 4; // Power of two, ring pointers wrap

	localparam logic [ITER_W-1:0] MAX_ITER = 5'd31;

	// Top-left corner of the view, -1.5 and -1.0
	localparam logic signed [COORD_W-1:0] START_X = -(32'sd3 <<< (FRAC_BITS - 1));
	localparam logic signed [COORD_W-1:0] START_Y = -(32'sd1 <<< FRAC_BITS);

	// 3.0 wide and 2.0 high across the panel
	localparam logic signed [COORD_W-1:0] STEP_X = (32'sd3 <<< FRAC_BITS) / LCD_W;
	localparam logic signed [COORD_W-1:0] STEP_Y = (32'sd2 <<< FRAC_BITS) / LCD_H;

	// c = -1.2501 - 0.25i
	localparam logic signed [COORD_W-1:0] INIT_CR = -32'sd10241;
	localparam logic signed [COORD_W-1:0] INIT_CI = -32'sd2048;

	localparam logic signed [COORD_W-1:0] ESCAPE_LIMIT = 32'sd4 <<< FRAC_BITS;

	// RGB565 colour from an iteration count
	function automatic logic [15:0] julia_color(input logic [ITER_W-1:0] n);
		return {n, n, 1'b0, MAX_ITER - n};
	endfunction

endpackage

// ==== lcd_pkg.sv ====
package lcd_pkg;

	// Bus transaction kinds
	typedef enum logic [1:0] {
		OP_REG,  // Index byte, then two data bytes
		OP_CMD,  // Index byte only
		OP_DATA  // Two data bytes
	} lcd_op_e;

	localparam logic [7:0] CMD_CURSOR_X = 8'h4E;
	localparam logic [7:0] CMD_CURSOR_Y = 8'h4F;
	localparam logic [7:0] CMD_RAM_WRITE = 8'h22;

	// Timing in clock cycles
	localparam logic [7:0] STROBE_CYCLES = 8'd2; // wr low, and wr high, per byte
	localparam logic [7:0] RESET_CYCLES = 8'd20;
	localparam logic [7:0] POWER_CYCLES = 8'd40;
	localparam logic [7:0] INIT_GAP_CYCLES = 8'd10;

	localparam logic [5:0] INIT_COUNT = 6'd41;

	// Register index in 23:16, value in 15:0
	localparam logic [23:0] INIT_TABLE [INIT_COUNT] = '{
		24'h00_0001, // Oscillator on
		24'h03_A8A4, // Power control 1
		24'h0C_0000,
		24'h0D_080C,
		24'h0E_2B00,
		24'h1E_00B7, // Power control 5
		24'h01_2B3F, // Driver output, REV BGR TB
		24'h02_0600,
		24'h10_0000, // Leave sleep
		24'h11_6058, // Entry mode
		24'h05_0000,
		24'h06_0000,
		24'h16_EF1C,
		24'h17_0003,
		24'h07_0233, // Display control
		24'h0B_0000,
		24'h0F_0000,
		24'h41_0000,
		24'h42_0000,
		24'h48_0000, // Screen start
		24'h49_013F, // Screen end
		24'h4A_0000,
		24'h4B_0000,
		24'h44_EF00, // Horizontal RAM window
		24'h45_0000,
		24'h46_013F, // Vertical RAM window
		// Gamma
		24'h30_0707,
		24'h31_0204,
		24'h32_0204,
		24'h33_0502,
		24'h34_0507,
		24'h35_0204,
		24'h36_0204,
		24'h37_0502,
		24'h3A_0302,
		24'h3B_0302,
		24'h23_0000,
		24'h24_0000,
		24'h25_8000,
		24'h4F_0000,
		24'h4E_0000
	};

endpackage

// ==== julia_engine.sv ====
module julia_engine (
	input  logic                                 clk,
	input  logic                                 unc_reset,
	input  logic                                 start,
	input  logic signed [julia_pkg::COORD_W-1:0] point_x,
	input  logic signed [julia_pkg::COORD_W-1:0] point_y,
	input  logic                                 result_release,
	output logic                                 busy,
	output logic                                 done,
	output logic        [julia_pkg::ITER_W-1:0]  iter
);

	typedef enum logic [1:0] {E_IDLE, E_RUN, E_HOLD} eng_state_e;

	eng_state_e state;

	logic signed [julia_pkg::COORD_W-1:0] zx, zy;
	logic signed [2*julia_pkg::COORD_W-1:0] zx_w, zy_w;
	logic signed [2*julia_pkg::COORD_W-1:0] zx_sq, zy_sq, zxy;
	logic signed [julia_pkg::COORD_W-1:0] xx, yy, xy;
	logic [julia_pkg::ITER_W-1:0] count;
	logic finish;

	always_comb begin
		zx_w = {{julia_pkg::COORD_W{zx[julia_pkg::COORD_W-1]}}, zx};
		zy_w = {{julia_pkg::COORD_W{zy[julia_pkg::COORD_W-1]}}, zy};
		zx_sq = zx_w * zx_w;
		zy_sq = zy_w * zy_w;
		zxy = zx_w * zy_w;
		// Arithmetic shift by FRAC_BITS, kept at single width
		xx = zx_sq[julia_pkg::FRAC_BITS +: julia_pkg::COORD_W];
		yy = zy_sq[julia_pkg::FRAC_BITS +: julia_pkg::COORD_W];
		xy = zxy[julia_pkg::FRAC_BITS +: julia_pkg::COORD_W];
		finish = ((xx + yy) > julia_pkg::ESCAPE_LIMIT) || (count == julia_pkg::MAX_ITER);
	end

	always_ff @(posedge clk) begin
		if (unc_reset) begin
			state <= E_IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				E_IDLE: if (start) state <= E_RUN;
				E_RUN: begin
					if (finish) begin
						state <= E_HOLD;
						done <= 1'b1; // Count is frozen from here
					end
				end
				E_HOLD: if (result_release) state <= E_IDLE;
				default: state <= E_IDLE;
			endcase
		end
	end

	// One z = z^2 + c step per cycle
	always_ff @(posedge clk) begin
		if (state == E_IDLE && start) begin
			zx <= point_x;
			zy <= point_y;
			count <= '0;
		end else if (state == E_RUN && !finish) begin
			zx <= xx - yy + julia_pkg::INIT_CR;
			zy <= (xy <<< 1) + julia_pkg::INIT_CI;
			count <= count + 1'b1;
		end
	end

	assign busy = (state != E_IDLE);
	assign iter = count;

	// Dispatcher must only pick idle engines
	a_no_start_busy: assert property (@(posedge clk) disable iff (unc_reset) start |-> !busy)
		else $error("engine started while busy");

endmodule

// ==== julia_pixel_dispatch.sv ====
module julia_pixel_dispatch (
	input  logic        clk,
	input  logic        unc_reset,
	input  logic        pix_ready,
	output logic        pix_valid,
	output logic [15:0] pix_color,
	output logic        pix_last
);

	typedef logic [$clog2(julia_pkg::ENGINE_COUNT)-1:0] eng_idx_t;
	typedef logic [$clog2(julia_pkg::ENGINE_COUNT):0] fill_t;
	typedef logic [$clog2(julia_pkg::LCD_W)-1:0] col_t;
	typedef logic [$clog2(julia_pkg::LCD_H)-1:0] row_t;

	logic signed [julia_pkg::COORD_W-1:0] cur_x, cur_y;
	col_t col;
	row_t row;
	logic point_last;

	logic [julia_pkg::ENGINE_COUNT-1:0] eng_start, eng_busy, eng_done, eng_release;
	logic [julia_pkg::ENGINE_COUNT-1:0] has_result; // Engine holds a finished count
	logic [julia_pkg::ITER_W-1:0] eng_iter [julia_pkg::ENGINE_COUNT];

	// Ring of issue tags, oldest at rd_ptr
	eng_idx_t ring_eng [julia_pkg::ENGINE_COUNT];
	logic ring_last [julia_pkg::ENGINE_COUNT];
	eng_idx_t wr_ptr, rd_ptr;
	fill_t fill;

	eng_idx_t free_idx, head_idx;
	logic issue, deliver;

	// Lowest idle engine takes the next point
	always_comb begin
		issue = 1'b0;
		free_idx = '0;
		for (int k = julia_pkg::ENGINE_COUNT - 1; k >= 0; k--) begin
			if (!eng_busy[k]) begin
				issue = 1'b1;
				free_idx = eng_idx_t'(k);
			end
		end
		eng_start = '0;
		if (issue) eng_start[free_idx] = 1'b1;
	end

	assign point_last = (col == col_t'(julia_pkg::LCD_W - 1)) &&
			(row == row_t'(julia_pkg::LCD_H - 1));

	assign head_idx = ring_eng[rd_ptr];
	assign pix_valid = (fill != '0) && has_result[head_idx];
	assign pix_last = ring_last[rd_ptr];
	assign pix_color = julia_pkg::julia_color(eng_iter[head_idx]);
	assign deliver = pix_valid && pix_ready;

	always_comb begin
		eng_release = '0;
		if (deliver) eng_release[head_idx] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (unc_reset) begin
			cur_x <= julia_pkg::START_X;
			cur_y <= julia_pkg::START_Y;
			col <= '0;
			row <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			has_result <= '0;
		end else begin
			if (issue) begin
				wr_ptr <= wr_ptr + 1'b1;
				if (col == col_t'(julia_pkg::LCD_W - 1)) begin
					col <= '0;
					cur_x <= julia_pkg::START_X;
					if (point_last) begin // Wrap to the next frame
						row <= '0;
						cur_y <= julia_pkg::START_Y;
					end else begin
						row <= row + 1'b1;
						cur_y <= cur_y + julia_pkg::STEP_Y;
					end
				end else begin
					col <= col + 1'b1;
					cur_x <= cur_x + julia_pkg::STEP_X;
				end
			end
			if (deliver) rd_ptr <= rd_ptr + 1'b1;
			fill <= fill + fill_t'(issue) - fill_t'(deliver);
			has_result <= (has_result | eng_done) & ~eng_release;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			ring_eng[wr_ptr] <= free_idx;
			ring_last[wr_ptr] <= point_last;
		end
	end

	for (genvar k = 0; k < julia_pkg::ENGINE_COUNT; k++) begin : g_engine
		julia_engine i_julia_engine (
			.clk            (clk),
			.unc_reset      (unc_reset),
			.start          (eng_start[k]),
			.point_x        (cur_x),
			.point_y        (cur_y),
			.result_release (eng_release[k]),
			.busy           (eng_busy[k]),
			.done           (eng_done[k]),
			.iter           (eng_iter[k])
		);
	end

	// Stalled pixel must not change under the sequencer
	a_pix_hold: assert property (@(posedge clk) disable iff (unc_reset)
			pix_valid && !pix_ready |=> pix_valid && $stable(pix_color) && $stable(pix_last))
		else $error("pixel changed while stalled");

endmodule

// ==== lcd_bus_writer.sv ====
module lcd_bus_writer (
	input  logic            clk,
	input  logic            unc_reset,
	input  logic            req_valid,
	input  lcd_pkg::lcd_op_e req_op,
	input  logic [7:0]      req_index,
	input  logic [15:0]     req_value,
	output logic            req_ready,
	output logic [7:0]      tft_db,
	output logic            tft_rs,
	output logic            tft_wr,
	output logic            tft_cs
);

	typedef enum logic [1:0] {W_IDLE, W_LOW, W_HIGH, W_END} wr_state_e;

	wr_state_e state;
	logic [7:0] strobe_cnt;
	logic strobe_done;
	logic [1:0] bytes_left; // Bytes still queued after the current one
	logic [15:0] byte_sr;
	logic [1:0] rs_sr;

	logic [7:0] first_byte;
	logic first_rs;
	logic [15:0] rest_bytes;
	logic [1:0] rest_rs;
	logic [1:0] rest_count;

	// Split the request into its byte sequence
	always_comb begin
		case (req_op)
			lcd_pkg::OP_REG: begin
				first_byte = req_index;
				first_rs = 1'b0;
				rest_bytes = req_value;
				rest_rs = 2'b11;
				rest_count = 2'd2;
			end
			lcd_pkg::OP_CMD: begin
				first_byte = req_index;
				first_rs = 1'b0;
				rest_bytes = 16'h0000;
				rest_rs = 2'b00;
				rest_count = 2'd0;
			end
			default: begin
				first_byte = req_value[15:8]; // High byte first
				first_rs = 1'b1;
				rest_bytes = {req_value[7:0], 8'h00};
				rest_rs = 2'b10;
				rest_count = 2'd1;
			end
		endcase
	end

	assign req_ready = (state == W_IDLE);
	assign strobe_done = (strobe_cnt == lcd_pkg::STROBE_CYCLES - 8'd1);

	always_ff @(posedge clk) begin
		if (unc_reset) begin
			state <= W_IDLE;
			tft_cs <= 1'b1;
			tft_wr <= 1'b1;
			tft_rs <= 1'b0;
			strobe_cnt <= '0;
			bytes_left <= '0;
		end else begin
			case (state)
				W_IDLE: begin
					if (req_valid) begin
						tft_cs <= 1'b0;
						tft_wr <= 1'b0;
						tft_rs <= first_rs;
						bytes_left <= rest_count;
						strobe_cnt <= '0;
						state <= W_LOW;
					end
				end
				W_LOW: begin
					if (strobe_done) begin
						tft_wr <= 1'b1; // Panel latches db here
						strobe_cnt <= '0;
						state <= W_HIGH;
					end else begin
						strobe_cnt <= strobe_cnt + 8'd1;
					end
				end
				W_HIGH: begin
					if (strobe_done) begin
						strobe_cnt <= '0;
						if (bytes_left != 2'd0) begin
							tft_wr <= 1'b0;
							tft_rs <= rs_sr[1];
							bytes_left <= bytes_left - 2'd1;
							state <= W_LOW;
						end else begin
							tft_cs <= 1'b1;
							state <= W_END;
						end
					end else begin
						strobe_cnt <= strobe_cnt + 8'd1;
					end
				end
				default: state <= W_IDLE; // cs high for one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == W_IDLE && req_valid) begin
			tft_db <= first_byte;
			byte_sr <= rest_bytes;
			rs_sr <= rest_rs;
		end else if (state == W_HIGH && strobe_done && bytes_left != 2'd0) begin
			tft_db <= byte_sr[15:8];
			byte_sr <= {byte_sr[7:0], 8'h00};
			rs_sr <= {rs_sr[0], 1'b0};
		end
	end

	a_wr_in_cs: assert property (@(posedge clk) disable iff (unc_reset) !tft_wr |-> !tft_cs)
		else $error("wr strobe outside chip select");

endmodule

// ==== lcd_sequencer.sv ====
module lcd_sequencer (
	input  logic             clk,
	input  logic             unc_reset,
	input  logic             req_ready,
	input  logic             pix_valid,
	input  logic [15:0]      pix_color,
	input  logic             pix_last,
	output logic             req_valid,
	output lcd_pkg::lcd_op_e req_op,
	output logic [7:0]       req_index,
	output logic [15:0]      req_value,
	output logic             pix_ready,
	output logic             tft_reset
);

	typedef enum logic [3:0] {
		S_RST_HI,
		S_RST_LO,
		S_POWER,
		S_INIT,
		S_INIT_GAP,
		S_CUR_X,
		S_CUR_Y,
		S_RAM_CMD,
		S_PIXELS
	} seq_state_e;

	seq_state_e state;
	logic [7:0] wait_cnt;
	logic [7:0] wait_limit;
	logic wait_hit;
	logic [5:0] init_idx;
	logic accepted;

	always_comb begin
		case (state)
			S_RST_HI, S_RST_LO: wait_limit = lcd_pkg::RESET_CYCLES;
			S_POWER: wait_limit = lcd_pkg::POWER_CYCLES;
			S_INIT_GAP: wait_limit = lcd_pkg::INIT_GAP_CYCLES;
			default: wait_limit = 8'd0;
		endcase
	end

	// Waits only count while the writer sits idle
	assign wait_hit = (wait_limit != 8'd0) && req_ready && (wait_cnt == wait_limit - 8'd1);
	assign accepted = req_valid && req_ready;
	assign tft_reset = (state != S_RST_LO);

	always_comb begin
		req_valid = 1'b0;
		req_op = lcd_pkg::OP_REG;
		req_index = 8'h00;
		req_value = 16'h0000;
		pix_ready = 1'b0;
		case (state)
			S_INIT: begin
				req_valid = 1'b1;
				req_index = lcd_pkg::INIT_TABLE[init_idx][23:16];
				req_value = lcd_pkg::INIT_TABLE[init_idx][15:0];
			end
			S_CUR_X: begin
				req_valid = 1'b1;
				req_index = lcd_pkg::CMD_CURSOR_X;
			end
			S_CUR_Y: begin
				req_valid = 1'b1;
				req_index = lcd_pkg::CMD_CURSOR_Y;
			end
			S_RAM_CMD: begin
				req_valid = 1'b1;
				req_op = lcd_pkg::OP_CMD;
				req_index = lcd_pkg::CMD_RAM_WRITE;
			end
			S_PIXELS: begin
				req_valid = pix_valid;
				req_op = lcd_pkg::OP_DATA;
				req_value = pix_color;
				pix_ready = req_ready;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (unc_reset) begin
			state <= S_RST_HI;
			wait_cnt <= '0;
			init_idx <= '0;
		end else begin
			if (wait_limit == 8'd0 || wait_hit || !req_ready) wait_cnt <= '0;
			else wait_cnt <= wait_cnt + 8'd1;

			case (state)
				S_RST_HI: if (wait_hit) state <= S_RST_LO;
				S_RST_LO: if (wait_hit) state <= S_POWER;
				S_POWER: if (wait_hit) state <= S_INIT;
				S_INIT: begin
					if (accepted) begin
						init_idx <= init_idx + 6'd1;
						state <= S_INIT_GAP;
					end
				end
				S_INIT_GAP: begin
					if (wait_hit) state <= (init_idx == lcd_pkg::INIT_COUNT) ? S_CUR_X : S_INIT;
				end
				S_CUR_X: if (accepted) state <= S_CUR_Y;
				S_CUR_Y: if (accepted) state <= S_RAM_CMD;
				S_RAM_CMD: if (accepted) state <= S_PIXELS;
				S_PIXELS: if (accepted && pix_last) state <= S_CUR_X; // Next frame
				default: state <= S_RST_HI;
			endcase
		end
	end

endmodule

// ==== julia_lcd_top.sv ====
module julia_lcd_top (
	input  logic       clk,
	input  logic       unc_reset,
	output logic [7:0] tft_db,
	output logic       tft_rs,
	output logic       tft_wr,
	output logic       tft_cs,
	output logic       tft_reset
);

	logic pix_valid, pix_ready, pix_last;
	logic [15:0] pix_color;

	logic req_valid, req_ready;
	lcd_pkg::lcd_op_e req_op;
	logic [7:0] req_index;
	logic [15:0] req_value;

	julia_pixel_dispatch i_julia_pixel_dispatch (
		.clk       (clk),
		.unc_reset (unc_reset),
		.pix_ready (pix_ready),
		.pix_valid (pix_valid),
		.pix_color (pix_color),
		.pix_last  (pix_last)
	);

	lcd_sequencer i_lcd_sequencer (
		.clk       (clk),
		.unc_reset (unc_reset),
		.req_ready (req_ready),
		.pix_valid (pix_valid),
		.pix_color (pix_color),
		.pix_last  (pix_last),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_index (req_index),
		.req_value (req_value),
		.pix_ready (pix_ready),
		.tft_reset (tft_reset)
	);

	lcd_bus_writer i_lcd_bus_writer (
		.clk       (clk),
		.unc_reset (unc_reset),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_index (req_index),
		.req_value (req_value),
		.req_ready (req_ready),
		.tft_db    (tft_db),
		.tft_rs    (tft_rs),
		.tft_wr    (tft_wr),
		.tft_cs    (tft_cs)
	);

endmodule

// ==== tb_julia_lcd.sv ====
module tb_julia_lcd;

	localparam int PIXELS = julia_pkg::LCD_W * julia_pkg::LCD_H;
	localparam int BYTE_CYCLES = 2 * int'(lcd_pkg::STROBE_CYCLES);
	localparam int REG_CYCLES = 3 * BYTE_CYCLES + 2;
	localparam int CMD_CYCLES = BYTE_CYCLES + 2;
	localparam int SETUP_CYCLES = 3 * (2 * REG_CYCLES + CMD_CYCLES); // Headers of three frames
	localparam int TIMEOUT_CYCLES = 2 * (8 + 2 * int'(lcd_pkg::RESET_CYCLES)
			+ int'(lcd_pkg::POWER_CYCLES)
			+ 41 * (REG_CYCLES + int'(lcd_pkg::INIT_GAP_CYCLES))
			+ 2 * PIXELS * (int'(julia_pkg::MAX_ITER) + 10)
			+ SETUP_CYCLES);

	// Expected register writes with the index in 23:16 and the value in 15:0
	localparam logic [23:0] INIT_REF [41] = '{
		24'h000001, 24'h03A8A4, 24'h0C0000, 24'h0D080C, 24'h0E2B00, 24'h1E00B7,
		24'h012B3F, 24'h020600, 24'h100000, 24'h116058, 24'h050000, 24'h060000,
		24'h16EF1C, 24'h170003, 24'h070233, 24'h0B0000, 24'h0F0000, 24'h410000,
		24'h420000, 24'h480000, 24'h49013F, 24'h4A0000, 24'h4B0000, 24'h44EF00,
		24'h450000, 24'h46013F, 24'h300707, 24'h310204, 24'h320204, 24'h330502,
		24'h340507, 24'h350204, 24'h360204, 24'h370502, 24'h3A0302, 24'h3B0302,
		24'h230000, 24'h240000, 24'h258000, 24'h4F0000, 24'h4E0000
	};

	logic clk;
	logic unc_reset;
	logic [7:0] tft_db;
	logic tft_rs;
	logic tft_wr;
	logic tft_cs;
	logic tft_reset;

	// Monitor state
	int cycles;
	logic prev_wr, prev_cs, prev_reset;
	int reset_falls;
	logic reset_done;
	int low_cycles;
	logic [7:0] low_db;
	logic low_rs;
	int byte_count;
	logic [7:0] txn_bytes [4];
	logic txn_rs [4];

	// Position in the expected transaction stream
	int init_pos;
	int frame_pos; // 0 and 1 cursor, 2 RAM command, then pixels
	int frame_no;
	logic run_complete;

	julia_lcd_top i_julia_lcd_top (
		.clk       (clk),
		.unc_reset (unc_reset),
		.tft_db    (tft_db),
		.tft_rs    (tft_rs),
		.tft_wr    (tft_wr),
		.tft_cs    (tft_cs),
		.tft_reset (tft_reset)
	);

	always #2 clk = ~clk;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		stop_with_failure($sformatf("ERROR %s expected %0h actual %0h", test, expected, actual));
	endtask

	// Escape time of one point with z tested before each step
	function automatic int escape_count(input int px, input int py);
		int zx;
		int zy;
		int xx;
		int yy;
		int xy;
		int n;
		logic finished;
		zx = px;
		zy = py;
		n = 0;
		finished = 1'b0;
		while (!finished) begin
			xx = int'((longint'(zx) * longint'(zx)) >>> julia_pkg::FRAC_BITS);
			yy = int'((longint'(zy) * longint'(zy)) >>> julia_pkg::FRAC_BITS);
			xy = int'((longint'(zx) * longint'(zy)) >>> julia_pkg::FRAC_BITS);
			if ((xx + yy) > int'(julia_pkg::ESCAPE_LIMIT) || n == int'(julia_pkg::MAX_ITER)) begin
				finished = 1'b1;
			end else begin
				zx = xx - yy + int'(julia_pkg::INIT_CR);
				zy = 2 * xy + int'(julia_pkg::INIT_CI);
				n = n + 1;
			end
		end
		return n;
	endfunction

	// n in red and green, 31 - n in blue
	function automatic logic [15:0] pixel_color(input int n);
		int packed_color;
		packed_color = (n << 11) | (n << 6) | (31 - n);
		return packed_color[15:0];
	endfunction

	task automatic check_reg(input logic [7:0] index, input logic [15:0] value);
		if (init_pos < 41) begin
			assert ({index, value} == INIT_REF[init_pos])
				else report_mismatch($sformatf("init_write_%0d", init_pos),
					32'(INIT_REF[init_pos]), 32'({index, value}));
			init_pos = init_pos + 1;
		end else if (frame_pos == 0) begin
			assert ({index, value} == 24'h4E0000)
				else report_mismatch($sformatf("frame_%0d_cursor_x", frame_no),
					32'h4E0000, 32'({index, value}));
			frame_pos = 1;
			if (frame_no == 2) run_complete = 1'b1; // Two frames closed off
		end else if (frame_pos == 1) begin
			assert ({index, value} == 24'h4F0000)
				else report_mismatch($sformatf("frame_%0d_cursor_y", frame_no),
					32'h4F0000, 32'({index, value}));
			frame_pos = 2;
		end else begin
			stop_with_failure($sformatf("register write %0h in the pixel stream of frame %0d",
				index, frame_no));
		end
	endtask

	task automatic check_cmd(input logic [7:0] index);
		assert (init_pos == 41 && frame_pos == 2)
			else stop_with_failure("command byte outside the frame header");
		assert (index == 8'h22)
			else report_mismatch($sformatf("frame_%0d_ram_write", frame_no),
				32'h22, 32'(index));
		frame_pos = 3;
	endtask

	task automatic check_data(input logic [15:0] color);
		int pix;
		int px;
		int py;
		logic [15:0] expected;
		assert (init_pos == 41 && frame_pos >= 3 && frame_pos < 3 + PIXELS)
			else stop_with_failure("pixel data outside a frame");
		pix = frame_pos - 3;
		px = int'(julia_pkg::START_X) + (pix % julia_pkg::LCD_W) * int'(julia_pkg::STEP_X);
		py = int'(julia_pkg::START_Y) + (pix / julia_pkg::LCD_W) * int'(julia_pkg::STEP_Y);
		expected = pixel_color(escape_count(px, py));
		assert (color == expected)
			else report_mismatch($sformatf("frame_%0d_pixel_%0d", frame_no, pix),
				32'(expected), 32'(color));
		frame_pos = frame_pos + 1;
		if (frame_pos == 3 + PIXELS) begin
			frame_pos = 0;
			frame_no = frame_no + 1;
		end
	endtask

	// Decode the bytes of one chip select window by their rs tags
	task automatic finish_txn();
		if (byte_count == 3 && !txn_rs[0] && txn_rs[1] && txn_rs[2]) begin
			check_reg(txn_bytes[0], {txn_bytes[1], txn_bytes[2]});
		end else if (byte_count == 1 && !txn_rs[0]) begin
			check_cmd(txn_bytes[0]);
		end else if (byte_count == 2 && txn_rs[0] && txn_rs[1]) begin
			check_data({txn_bytes[0], txn_bytes[1]});
		end else begin
			stop_with_failure($sformatf("malformed bus transaction with %0d bytes", byte_count));
		end
	endtask

	// Bus monitor working on values sampled at the clock edge
	always @(posedge clk) begin
		if (unc_reset) begin
			cycles = 0;
			prev_wr = 1'b1;
			prev_cs = 1'b1;
			prev_reset = 1'b1;
			reset_falls = 0;
			reset_done = 1'b0;
			low_cycles = 0;
			byte_count = 0;
			init_pos = 0;
			frame_pos = 0;
			frame_no = 0;
		end else if (!run_complete) begin
			cycles = cycles + 1;
			if (cycles >= TIMEOUT_CYCLES) stop_with_failure("timeout: frames not completed");

			if (prev_reset && !tft_reset) reset_falls = reset_falls + 1;
			if (!prev_reset && tft_reset) reset_done = 1'b1;
			assert (reset_falls <= 1) else stop_with_failure("tft_reset went low more than once");
			if (!reset_done) begin
				assert (tft_cs && tft_wr) else stop_with_failure("bus active during panel reset");
			end

			if (!tft_wr) begin
				if (prev_wr) begin
					low_cycles = 1;
					low_db = tft_db;
					low_rs = tft_rs;
				end else begin
					low_cycles = low_cycles + 1;
					assert (tft_db == low_db && tft_rs == low_rs)
						else stop_with_failure("db or rs changed while wr was low");
				end
			end else if (!prev_wr) begin
				assert (low_cycles == int'(lcd_pkg::STROBE_CYCLES))
					else report_mismatch("wr_low_width", 32'(lcd_pkg::STROBE_CYCLES),
						32'(low_cycles));
				if (byte_count < 4) begin
					txn_bytes[byte_count] = tft_db;
					txn_rs[byte_count] = tft_rs;
				end
				byte_count = byte_count + 1;
			end

			if (prev_cs && !tft_cs) byte_count = 0;
			if (!prev_cs && tft_cs) finish_txn();

			prev_wr = tft_wr;
			prev_cs = tft_cs;
			prev_reset = tft_reset;
		end
	end

	initial begin
		clk = 1'b0;
		unc_reset = 1'b1;
		run_complete = 1'b0;
		repeat (8) @(posedge clk);
		unc_reset <= 1'b0;
		wait (run_complete);
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== verilog.f ====
julia_pkg.sv
lcd_pkg.sv
julia_engine.sv
julia_pixel_dispatch.sv
lcd_bus_writer.sv
lcd_sequencer.sv
julia_lcd_top.sv
tb_julia_lcd.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_julia_lcd -f verilog.f && ./obj_dir/Vtb_julia_lcd || exit 1
